// File: tb.f
+incdir+tb
rtl/isa_pkg.sv
rtl/net_pkg.sv
rtl/net_control.sv
rtl/instr_mem.sv
rtl/reg_file.sv
rtl/fetch_unit.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/core.sv
tb/core_tb.sv

// File: Makefile
TOP = core_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f tb.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f tb.f -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Simulation finished: PASS"

clean:
	rm -rf obj_dir

// File: tb/core_ref.svh
`ifndef CORE_REF_SVH
`define CORE_REF_SVH

// R0 always reads as zero
function automatic isa_pkg::data_t read_model_reg(isa_pkg::reg_addr_t addr);
    isa_pkg::data_t val;
    val = (addr == '0) ? '0 : model_regs[addr];
    return val;
endfunction

// Expected commit goes on the queues and into the register copy
function automatic void queue_commit(isa_pkg::reg_addr_t rd, isa_pkg::data_t data);
    exp_rd_q.push_back(rd);
    exp_data_q.push_back(data);
    model_regs[rd] = data;
endfunction

// Empty program placed at a base address
function automatic void clear_prog(int base);
    prog_base = isa_pkg::imem_addr_t'(base);
    prog_len = 0;
endfunction

function automatic void add_instr(isa_pkg::opcode_e op, int rd, int rs_imm);
    prog[prog_len].opcode = op;
    prog[prog_len].rd = isa_pkg::reg_addr_t'(rd);
    prog[prog_len].rs_imm = isa_pkg::reg_addr_t'(rs_imm);
    prog_len++;
endfunction

// Runs the program one instruction at a time from the register copy
// Returns the number of commits or -1 if it leaves the program or never waits
function automatic int run_ref(isa_pkg::imem_addr_t start_pc);
    isa_pkg::imem_addr_t pc;
    isa_pkg::imem_addr_t new_pc;
    isa_pkg::instr_t     ins;
    isa_pkg::data_t      a;
    isa_pkg::data_t      b;
    isa_pkg::data_t      res;
    logic                wr;
    int                  idx;
    int                  off;
    int                  commits;
    pc = start_pc;
    commits = 0;
    for (int step = 0; step < 4096; step++)
    begin
        idx = int'(pc) - int'(prog_base);
        if (idx < 0 || idx >= prog_len)
        begin
            return -1;
        end
        ins = prog[idx];
        a = read_model_reg(ins.rd);
        b = read_model_reg(ins.rs_imm);
        new_pc = isa_pkg::imem_addr_t'(int'(pc) + 1);
        off = int'($signed(ins.rs_imm));
        res = '0;
        wr = 1'b0;
        case (ins.opcode)
            isa_pkg::WAIT:
            begin
                return commits;
            end
            isa_pkg::ADDU:
            begin
                res = a + b;
                wr = 1'b1;
            end
            isa_pkg::SUBU:
            begin
                res = a - b;
                wr = 1'b1;
            end
            isa_pkg::AND:
            begin
                res = a & b;
                wr = 1'b1;
            end
            isa_pkg::OR:
            begin
                res = a | b;
                wr = 1'b1;
            end
            isa_pkg::MOV:
            begin
                res = b;
                wr = 1'b1;
            end
            isa_pkg::BEQZ,
            isa_pkg::BNEQZ:
            begin
                // Taken when the zero test agrees with the opcode
                if ((a == '0) == (ins.opcode == isa_pkg::BEQZ))
                begin
                    new_pc = isa_pkg::imem_addr_t'(int'(pc) + off);
                end
            end
            isa_pkg::JALR:
            begin
                // Link is the address after the jump
                res = isa_pkg::data_t'(new_pc);
                wr = 1'b1;
                new_pc = b[9:0];
            end
            default:
            begin
                res = '0;
            end
        endcase
        if (wr)
        begin
            queue_commit(ins.rd, res);
            commits++;
        end
        pc = new_pc;
    end
    return -1;
endfunction

// Random mix of ALU ops and branches over r0 to r7
// Offsets only point forward and never past the closing WAIT
function automatic void build_random_prog(int len);
    int op_sel;
    int room;
    int rd_sel;
    int rs_sel;
    isa_pkg::opcode_e op;
    clear_prog(0);
    for (int i = 0; i < len - 1; i++)
    begin
        op_sel = int'($unsigned($random(seed)) % 7);
        rd_sel = int'($unsigned($random(seed)) % 8);
        rs_sel = int'($unsigned($random(seed)) % 8);
        case (op_sel)
            0: op = isa_pkg::ADDU;
            1: op = isa_pkg::SUBU;
            2: op = isa_pkg::AND;
            3: op = isa_pkg::OR;
            4: op = isa_pkg::MOV;
            5: op = isa_pkg::BEQZ;
            default: op = isa_pkg::BNEQZ;
        endcase
        if (op_sel >= 5)
        begin
            room = (len - 1 - i > 15) ? 15 : len - 1 - i;
            rs_sel = 1 + int'($unsigned($random(seed)) % room);
        end
        add_instr(op, rd_sel, rs_sel);
    end
    add_instr(isa_pkg::WAIT, 0, 0);
endfunction

`endif

// File: tb/core_tb.sv
`timescale 1ns/1ns

module core_tb;

    localparam net_pkg::net_id_t kCoreId = 10'd5;
    localparam net_pkg::net_id_t kOtherId = 10'd6;
    localparam int kPrograms = 15;
    localparam int kMaxInstr = 64;
    // Room for the longest run of every program plus loading
    localparam int kCycleLimit = kPrograms * (kMaxInstr * 4 + 200);

    logic                clk;
    logic                n_reset;
    logic                net_valid;
    net_pkg::net_id_t    net_id;
    net_pkg::net_op_e    net_op;
    isa_pkg::imem_addr_t net_addr;
    isa_pkg::data_t      net_data;
    logic                idle;
    logic                exception;
    logic                commit_valid;
    isa_pkg::reg_addr_t  commit_rd;
    isa_pkg::data_t      commit_data;

    integer              seed;
    int                  cycles;
    int                  commit_count;
    int                  count_before;
    isa_pkg::data_t      model_regs [32];
    isa_pkg::instr_t     prog [kMaxInstr];
    int                  prog_len;
    isa_pkg::imem_addr_t prog_base;
    isa_pkg::reg_addr_t  exp_rd_q [$];
    isa_pkg::data_t      exp_data_q [$];

    `include "core_ref.svh"

    core #(
        .core_id_p (kCoreId)
    ) dut_i (
        .clk            (clk),
        .n_reset        (n_reset),
        .net_valid_i    (net_valid),
        .net_id_i       (net_id),
        .net_op_i       (net_op),
        .net_addr_i     (net_addr),
        .net_data_i     (net_data),
        .idle_o         (idle),
        .exception_o    (exception),
        .commit_valid_o (commit_valid),
        .commit_rd_o    (commit_rd),
        .commit_data_o  (commit_data)
    );

    always #5 clk = ~clk;

    task automatic fail_run(string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_value(string name, logic [31:0] got, logic [31:0] want);
        if (got !== want)
        begin
            fail_run($sformatf("MISMATCH at %0t ns: %s is 0x%0h, expected 0x%0h",
                $time, name, got, want));
        end
    endtask

    // Called at a falling edge, strobe lasts one cycle
    task automatic send_packet(net_pkg::net_id_t id, net_pkg::net_op_e op,
        isa_pkg::imem_addr_t addr, isa_pkg::data_t data);
        net_valid = 1'b1;
        net_id = id;
        net_op = op;
        net_addr = addr;
        net_data = data;
        @(negedge clk);
        net_valid = 1'b0;
    endtask

    task automatic set_reg(int r, isa_pkg::data_t v);
        send_packet(kCoreId, net_pkg::NET_REG, isa_pkg::imem_addr_t'(r), v);
        model_regs[r] = v;
    endtask

    // Two NOP words after the program keep the idle pipe clean
    task automatic load_prog();
        for (int i = 0; i < prog_len + 2; i++)
        begin
            send_packet(kCoreId, net_pkg::NET_INSTR,
                isa_pkg::imem_addr_t'(int'(prog_base) + i),
                (i < prog_len) ? isa_pkg::data_t'(prog[i]) : '0);
        end
    endtask

    // Expected commits are queued before the start packet goes out
    task automatic run_prog();
        if (run_ref(prog_base) < 0)
        begin
            fail_run("Reference model never reached a WAIT inside the program");
        end
        send_packet(kCoreId, net_pkg::NET_PC, prog_base, '0);
        while (!idle)
        begin
            @(negedge clk);
        end
        if (exp_rd_q.size() != 0)
        begin
            fail_run($sformatf("%0d expected commits never appeared", exp_rd_q.size()));
        end
    endtask

    // Random values with some zeros so both branch senses occur
    task automatic preload_random_regs();
        isa_pkg::data_t v;
        for (int r = 1; r < 8; r++)
        begin
            v = $random(seed);
            if (v[1:0] == 2'b00)
            begin
                v = '0;
            end
            set_reg(r, v);
        end
    endtask

    // Commit trace checked in order at the rising edge
    always @(posedge clk)
    begin
        if (n_reset && commit_valid)
        begin
            if (exp_rd_q.size() == 0)
            begin
                fail_run($sformatf("Unexpected commit to r%0d at %0t ns", commit_rd, $time));
            end
            else
            begin
                check_value("commit_rd_o", 32'(commit_rd), 32'(exp_rd_q.pop_front()));
                check_value("commit_data_o", commit_data, exp_data_q.pop_front());
                commit_count++;
            end
        end
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles > kCycleLimit)
        begin
            fail_run($sformatf("Timeout after %0d cycles", kCycleLimit));
        end
    end

    initial
    begin
        seed = 67891;
        clk = 1'b0;
        n_reset = 1'b0;
        net_valid = 1'b0;
        net_id = '0;
        net_op = net_pkg::NET_INSTR;
        net_addr = '0;
        net_data = '0;
        cycles = 0;
        commit_count = 0;
        prog_len = 0;
        prog_base = '0;
        for (int r = 0; r < 32; r++)
        begin
            model_regs[r] = '0;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        n_reset = 1'b1;
        check_value("idle_o", 32'(idle), 32'd1);
        check_value("exception_o", 32'(exception), 32'd0);
        check_value("commit_valid_o", 32'(commit_valid), 32'd0);

        // Register array has no reset
        for (int r = 1; r < 32; r++)
        begin
            set_reg(r, '0);
        end

        // Independent ALU ops at a nonzero base
        clear_prog(40);
        add_instr(isa_pkg::ADDU, 3, 1);
        add_instr(isa_pkg::SUBU, 4, 2);
        add_instr(isa_pkg::AND, 5, 1);
        add_instr(isa_pkg::OR, 6, 2);
        add_instr(isa_pkg::MOV, 7, 2);
        add_instr(isa_pkg::WAIT, 0, 0);
        set_reg(1, 32'h1234_5678);
        set_reg(2, 32'h0f0f_00ff);
        set_reg(3, 32'd100);
        set_reg(4, 32'd7);
        set_reg(5, 32'hffff_0000);
        set_reg(6, 32'h8000_0001);
        load_prog();
        run_prog();

        // Each op needs the one just before it
        clear_prog(0);
        add_instr(isa_pkg::ADDU, 1, 1);
        add_instr(isa_pkg::ADDU, 1, 1);
        add_instr(isa_pkg::SUBU, 2, 1);
        add_instr(isa_pkg::MOV, 3, 2);
        add_instr(isa_pkg::OR, 3, 1);
        add_instr(isa_pkg::AND, 1, 3);
        add_instr(isa_pkg::ADDU, 4, 1);
        add_instr(isa_pkg::WAIT, 0, 0);
        load_prog();
        run_prog();

        // Both branch senses taken and not taken then a JALR to 11
        clear_prog(0);
        add_instr(isa_pkg::BEQZ, 1, 2);
        add_instr(isa_pkg::ADDU, 2, 2);
        add_instr(isa_pkg::BNEQZ, 1, 2);
        add_instr(isa_pkg::ADDU, 4, 2);
        add_instr(isa_pkg::BNEQZ, 2, 3);
        add_instr(isa_pkg::MOV, 5, 2);
        add_instr(isa_pkg::MOV, 6, 2);
        add_instr(isa_pkg::BEQZ, 2, 2);
        add_instr(isa_pkg::JALR, 7, 3);
        add_instr(isa_pkg::MOV, 8, 2);
        add_instr(isa_pkg::MOV, 9, 2);
        add_instr(isa_pkg::SUBU, 7, 2);
        add_instr(isa_pkg::WAIT, 0, 0);
        set_reg(1, '0);
        set_reg(2, 32'd7);
        set_reg(3, 32'd11);
        load_prog();
        run_prog();

        repeat (10)
        begin
            preload_random_regs();
            build_random_prog(8 + int'($unsigned($random(seed)) % 24));
            load_prog();
            run_prog();
        end

        // Foreign packets would clobber the program and start it early
        clear_prog(0);
        add_instr(isa_pkg::ADDU, 2, 1);
        add_instr(isa_pkg::MOV, 3, 2);
        add_instr(isa_pkg::SUBU, 3, 1);
        add_instr(isa_pkg::WAIT, 0, 0);
        set_reg(1, 32'd21);
        set_reg(2, 32'd4);
        load_prog();
        send_packet(kOtherId, net_pkg::NET_INSTR, '0, 32'h0000_ffff);
        send_packet(kOtherId, net_pkg::NET_REG, 10'd1, 32'hdead_beef);
        send_packet(kOtherId, net_pkg::NET_PC, '0, '0);
        check_value("idle_o", 32'(idle), 32'd1);
        run_prog();

        // Endless loop adding r1 into r2 keeps the core busy and committing
        clear_prog(0);
        add_instr(isa_pkg::ADDU, 2, 1);
        add_instr(isa_pkg::BNEQZ, 1, -1);
        add_instr(isa_pkg::WAIT, 0, 0);
        set_reg(1, 32'd1);
        load_prog();
        // Model stops at its step limit, far more commits than the loop gets to make
        void'(run_ref(prog_base));
        count_before = commit_count;
        send_packet(kCoreId, net_pkg::NET_PC, '0, '0);
        repeat (10) @(negedge clk);
        check_value("idle_o", 32'(idle), 32'd0);
        check_value("exception_o", 32'(exception), 32'd0);
        if (commit_count == count_before)
        begin
            fail_run("Loop program made no commits while running");
        end
        send_packet(kCoreId, net_pkg::NET_PC, '0, '0);
        // Pipe is frozen from here on
        count_before = commit_count;
        repeat (20)
        begin
            check_value("exception_o", 32'(exception), 32'd1);
            check_value("idle_o", 32'(idle), 32'd0);
            @(negedge clk);
        end
        check_value("commit count", 32'(commit_count), 32'(count_before));

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// File: rtl/core.sv
`timescale 1ns/1ns

module core #(
    parameter net_pkg::net_id_t core_id_p = '0
)
(
    input  logic                clk,
    input  logic                n_reset,
    input  logic                net_valid_i,
    input  net_pkg::net_id_t    net_id_i,
    input  net_pkg::net_op_e    net_op_i,
    input  isa_pkg::imem_addr_t net_addr_i,
    input  isa_pkg::data_t      net_data_i,
    output logic                idle_o,
    output logic                exception_o,
    output logic                commit_valid_o,
    output isa_pkg::reg_addr_t  commit_rd_o,
    output isa_pkg::data_t      commit_data_o
);

    logic                imem_we;
    logic                rf_net_we;
    logic                pc_load;
    logic                start_flush;
    logic                run;
    logic                stall_net;
    logic                stall;
    logic                flush;
    logic                redirect;
    isa_pkg::imem_addr_t redirect_pc;
    logic                wb_we;
    isa_pkg::reg_addr_t  wb_addr;
    isa_pkg::data_t      wb_data;
    logic                wait_commit;
    isa_pkg::instr_t     if_instr;
    isa_pkg::imem_addr_t if_pc;
    isa_pkg::instr_t     ex_instr;
    isa_pkg::imem_addr_t ex_pc;
    isa_pkg::data_t      ex_rd_val;
    isa_pkg::data_t      ex_rs_val;
    logic                ex_writes;

    // Register port conflict, network write vs instruction in execute
    assign ex_writes = isa_pkg::writes_rd(ex_instr.opcode);
    // Whole pipe freezes outside RUN
    assign stall = stall_net || (rf_net_we && ex_writes) || !run;
    assign flush = start_flush || redirect;

    net_control #(
        .core_id_p (core_id_p)
    ) net_control_i (
        .clk           (clk),
        .n_reset       (n_reset),
        .net_valid_i   (net_valid_i),
        .net_id_i      (net_id_i),
        .net_op_i      (net_op_i),
        .net_addr_i    (net_addr_i),
        .net_data_i    (net_data_i),
        .wait_commit_i (wait_commit),
        .stall_i       (stall),
        .imem_we_o     (imem_we),
        .rf_net_we_o   (rf_net_we),
        .pc_load_o     (pc_load),
        .start_flush_o (start_flush),
        .run_o         (run),
        .stall_net_o   (stall_net),
        .idle_o        (idle_o),
        .exception_o   (exception_o)
    );

    fetch_unit fetch_i (
        .clk           (clk),
        .n_reset       (n_reset),
        .stall_i       (stall),
        .pc_load_i     (pc_load),
        .net_addr_i    (net_addr_i),
        .net_data_i    (net_data_i),
        .imem_we_i     (imem_we),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .instr_o       (if_instr),
        .pc_o          (if_pc)
    );

    decode_stage decode_i (
        .clk         (clk),
        .n_reset     (n_reset),
        .stall_i     (stall),
        .flush_i     (flush),
        .instr_i     (if_instr),
        .pc_i        (if_pc),
        .rf_net_we_i (rf_net_we),
        .net_addr_i  (net_addr_i),
        .net_data_i  (net_data_i),
        .wb_we_i     (wb_we),
        .wb_addr_i   (wb_addr),
        .wb_data_i   (wb_data),
        .instr_o     (ex_instr),
        .pc_o        (ex_pc),
        .rd_val_o    (ex_rd_val),
        .rs_val_o    (ex_rs_val)
    );

    execute_stage execute_i (
        .instr_i       (ex_instr),
        .pc_i          (ex_pc),
        .rd_val_i      (ex_rd_val),
        .rs_val_i      (ex_rs_val),
        .stall_i       (stall),
        .redirect_o    (redirect),
        .redirect_pc_o (redirect_pc),
        .wb_we_o       (wb_we),
        .wb_addr_o     (wb_addr),
        .wb_data_o     (wb_data),
        .wait_commit_o (wait_commit)
    );

    // Commit trace is the instruction writeback as is
    assign commit_valid_o = wb_we;
    assign commit_rd_o = wb_addr;
    assign commit_data_o = wb_data;

endmodule

// File: rtl/execute_stage.sv
`timescale 1ns/1ns

module execute_stage
(
    input  isa_pkg::instr_t     instr_i,
    input  isa_pkg::imem_addr_t pc_i,
    input  isa_pkg::data_t      rd_val_i,
    input  isa_pkg::data_t      rs_val_i,
    input  logic                stall_i,
    output logic                redirect_o,
    output isa_pkg::imem_addr_t redirect_pc_o,
    output logic                wb_we_o,
    output isa_pkg::reg_addr_t  wb_addr_o,
    output isa_pkg::data_t      wb_data_o,
    output logic                wait_commit_o
);

    isa_pkg::data_t      result;
    isa_pkg::imem_addr_t branch_pc;
    isa_pkg::imem_addr_t link_pc;
    logic                taken;

    // Offset is sign extended to PC width
    assign branch_pc = pc_i + {{(isa_pkg::kImemAddrBits - isa_pkg::kRegAddrBits)
        {instr_i.rs_imm[isa_pkg::kRegAddrBits-1]}}, instr_i.rs_imm};
    assign link_pc = pc_i + isa_pkg::imem_addr_t'(1);

    always_comb
    begin
        result = '0;
        taken = 1'b0;
        redirect_pc_o = branch_pc;
        case (instr_i.opcode)
            isa_pkg::ADDU:  result = rd_val_i + rs_val_i;
            isa_pkg::SUBU:  result = rd_val_i - rs_val_i;
            isa_pkg::AND:   result = rd_val_i & rs_val_i;
            isa_pkg::OR:    result = rd_val_i | rs_val_i;
            isa_pkg::MOV:   result = rs_val_i;
            isa_pkg::BEQZ:  taken = (rd_val_i == '0);
            isa_pkg::BNEQZ: taken = (rd_val_i != '0);
            isa_pkg::JALR:
            begin
                // Link is zero extended, target is low bits of rs
                result = isa_pkg::data_t'(link_pc);
                taken = 1'b1;
                redirect_pc_o = rs_val_i[isa_pkg::kImemAddrBits-1:0];
            end
            default:        result = '0;
        endcase
        // Flushed slots must never steer fetch
        a_no_nop_redirect: assert (!(taken && (instr_i.opcode == isa_pkg::NOP)));
    end

    // Held instruction retries once the stall clears
    assign redirect_o = taken && !stall_i;
    assign wb_we_o = isa_pkg::writes_rd(instr_i.opcode) && !stall_i;
    assign wb_addr_o = instr_i.rd;
    assign wb_data_o = result;

    // Net control gates this with the stall itself
    assign wait_commit_o = (instr_i.opcode == isa_pkg::WAIT);

endmodule

// File: rtl/decode_stage.sv
`timescale 1ns/1ns

module decode_stage
(
    input  logic                clk,
    input  logic                n_reset,
    input  logic                stall_i,
    input  logic                flush_i,
    input  isa_pkg::instr_t     instr_i,
    input  isa_pkg::imem_addr_t pc_i,
    input  logic                rf_net_we_i,
    input  isa_pkg::imem_addr_t net_addr_i,
    input  isa_pkg::data_t      net_data_i,
    input  logic                wb_we_i,
    input  isa_pkg::reg_addr_t  wb_addr_i,
    input  isa_pkg::data_t      wb_data_i,
    output isa_pkg::instr_t     instr_o,
    output isa_pkg::imem_addr_t pc_o,
    output isa_pkg::data_t      rd_val_o,
    output isa_pkg::data_t      rs_val_o
);

    isa_pkg::instr_t     instr_1_r;
    isa_pkg::imem_addr_t pc_1_r;
    logic                w_en;
    isa_pkg::reg_addr_t  w_addr;
    isa_pkg::data_t      w_data;
    isa_pkg::data_t      rf_rs_val;
    isa_pkg::data_t      rf_rd_val;
    isa_pkg::data_t      rs_fwd;
    isa_pkg::data_t      rd_fwd;

    // Network write takes the port over a writeback
    assign w_en = rf_net_we_i || wb_we_i;
    assign w_addr = rf_net_we_i ? net_addr_i[isa_pkg::kRegAddrBits-1:0] : wb_addr_i;
    assign w_data = rf_net_we_i ? net_data_i : wb_data_i;

    reg_file rf_i (
        .clk       (clk),
        .rs_addr_i (instr_1_r.rs_imm),
        .rd_addr_i (instr_1_r.rd),
        .waddr_i   (w_addr),
        .we_i      (w_en),
        .wdata_i   (w_data),
        .rs_val_o  (rf_rs_val),
        .rd_val_o  (rf_rd_val)
    );

    // Same-cycle write bypasses the array, r0 never forwarded
    assign rs_fwd = (w_en && (w_addr == instr_1_r.rs_imm) && (w_addr != '0)) ? w_data : rf_rs_val;
    assign rd_fwd = (w_en && (w_addr == instr_1_r.rd) && (w_addr != '0)) ? w_data : rf_rd_val;

    always_ff @(posedge clk)
    begin
        if (!n_reset)
        begin
            instr_1_r <= '0;
            pc_1_r <= '0;
            instr_o <= '0;
            pc_o <= '0;
            rd_val_o <= '0;
            rs_val_o <= '0;
        end
        else if (flush_i)
        begin
            // All-zero word is NOP
            instr_1_r <= '0;
            instr_o <= '0;
        end
        else if (!stall_i)
        begin
            instr_1_r <= instr_i;
            pc_1_r <= pc_i;
            instr_o <= instr_1_r;
            pc_o <= pc_1_r;
            rd_val_o <= rd_fwd;
            rs_val_o <= rs_fwd;
        end
    end

endmodule

// File: rtl/fetch_unit.sv
`timescale 1ns/1ns

module fetch_unit
(
    input  logic                clk,
    input  logic                n_reset,
    input  logic                stall_i,
    input  logic                pc_load_i,
    input  isa_pkg::imem_addr_t net_addr_i,
    input  isa_pkg::data_t      net_data_i,
    input  logic                imem_we_i,
    input  logic                redirect_i,
    input  isa_pkg::imem_addr_t redirect_pc_i,
    output isa_pkg::instr_t     instr_o,
    output isa_pkg::imem_addr_t pc_o
);

    isa_pkg::imem_addr_t pc_r;
    isa_pkg::imem_addr_t pc_n;
    isa_pkg::imem_addr_t imem_addr;
    isa_pkg::instr_t     net_instr;

    // Next PC, network load first
    always_comb
    begin
        if (pc_load_i)
        begin
            pc_n = net_addr_i;
        end
        else if (redirect_i)
        begin
            pc_n = redirect_pc_i;
        end
        else if (stall_i)
        begin
            pc_n = pc_r;
        end
        else
        begin
            pc_n = pc_r + isa_pkg::imem_addr_t'(1);
        end
    end

    always_ff @(posedge clk)
    begin
        if (!n_reset)
        begin
            pc_r <= '0;
        end
        else
        begin
            pc_r <= pc_n;
        end
    end

    // Memory sees next PC so the word lines up with pc_r
    assign imem_addr = imem_we_i ? net_addr_i : pc_n;

    // Instruction sits in the low half of the packet data
    assign net_instr = isa_pkg::instr_t'(net_data_i[$bits(isa_pkg::instr_t)-1:0]);

    instr_mem imem_i (
        .clk     (clk),
        .addr_i  (imem_addr),
        .we_i    (imem_we_i),
        .wdata_i (net_instr),
        .rdata_o (instr_o)
    );

    assign pc_o = pc_r;

endmodule

// File: rtl/reg_file.sv
`timescale 1ns/1ns

module reg_file
(
    input  logic               clk,
    input  isa_pkg::reg_addr_t rs_addr_i,
    input  isa_pkg::reg_addr_t rd_addr_i,
    input  isa_pkg::reg_addr_t waddr_i,
    input  logic               we_i,
    input  isa_pkg::data_t     wdata_i,
    output isa_pkg::data_t     rs_val_o,
    output isa_pkg::data_t     rd_val_o
);

    isa_pkg::data_t regs [isa_pkg::kNumRegs];

    // Single write port, caller picks network or writeback
    always_ff @(posedge clk)
    begin
        if (we_i)
        begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // Register 0 is hardwired to zero on read
    assign rs_val_o = (rs_addr_i == '0) ? '0 : regs[rs_addr_i];
    assign rd_val_o = (rd_addr_i == '0) ? '0 : regs[rd_addr_i];

    // Write enable comes from both network decode and execute
    a_we_known: assert property (@(posedge clk) !$isunknown(we_i));

endmodule

// File: rtl/instr_mem.sv
`timescale 1ns/1ns

module instr_mem
(
    input  logic                clk,
    input  isa_pkg::imem_addr_t addr_i,
    input  logic                we_i,
    input  isa_pkg::instr_t     wdata_i,
    output isa_pkg::instr_t     rdata_o
);

    // Single port, contents only come from the network
    isa_pkg::instr_t mem [isa_pkg::kImemWords];

    always_ff @(posedge clk)
    begin
        if (we_i)
        begin
            mem[addr_i] <= wdata_i;
        end
        // Read data valid one cycle after the address
        rdata_o <= mem[addr_i];
    end

endmodule

// File: rtl/net_control.sv
`timescale 1ns/1ns

module net_control #(
    parameter net_pkg::net_id_t core_id_p = '0
)
(
    input  logic                clk,
    input  logic                n_reset,
    input  logic                net_valid_i,
    input  net_pkg::net_id_t    net_id_i,
    input  net_pkg::net_op_e    net_op_i,
    input  isa_pkg::imem_addr_t net_addr_i,
    input  isa_pkg::data_t      net_data_i,
    input  logic                wait_commit_i,
    input  logic                stall_i,
    output logic                imem_we_o,
    output logic                rf_net_we_o,
    output logic                pc_load_o,
    output logic                start_flush_o,
    output logic                run_o,
    output logic                stall_net_o,
    output logic                idle_o,
    output logic                exception_o
);

    net_pkg::core_state_e state_r;
    net_pkg::core_state_e state_n;
    logic id_match;
    logic pc_cmd;

    // Packet is ours only in its strobe cycle
    assign id_match = net_valid_i && (net_id_i == core_id_p);

    assign imem_we_o = id_match && (net_op_i == net_pkg::NET_INSTR);
    assign rf_net_we_o = id_match && (net_op_i == net_pkg::NET_REG);
    assign pc_cmd = id_match && (net_op_i == net_pkg::NET_PC);

    // PC write only starts the core from IDLE
    assign pc_load_o = pc_cmd && (state_r == net_pkg::IDLE);
    // Start also clears both stage registers
    assign start_flush_o = pc_load_o;

    // Imem port is shared with fetch
    assign stall_net_o = imem_we_o;

    assign run_o = (state_r == net_pkg::RUN);
    assign idle_o = (state_r == net_pkg::IDLE);

    always_comb
    begin
        state_n = state_r;
        case (state_r)
            net_pkg::IDLE:
            begin
                if (pc_load_o)
                begin
                    state_n = net_pkg::RUN;
                end
            end
            net_pkg::RUN:
            begin
                // Bad PC write wins over a WAIT in the same cycle
                if (pc_cmd)
                begin
                    state_n = net_pkg::ERR;
                end
                else if (wait_commit_i && !stall_i)
                begin
                    state_n = net_pkg::IDLE;
                end
            end
            default:
            begin
                state_n = net_pkg::ERR;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!n_reset)
        begin
            state_r <= net_pkg::IDLE;
            exception_o <= 1'b0;
        end
        else
        begin
            state_r <= state_n;
            // Sticky until reset
            exception_o <= exception_o || (pc_cmd && (state_r != net_pkg::IDLE));
        end
    end

    // Exception must hold once raised
    a_exc_sticky: assert property (@(posedge clk)
        n_reset && $past(n_reset) && $past(exception_o) |-> exception_o);

    // A strobed packet carries no unknown fields
    a_packet_known: assert property (@(posedge clk) disable iff (!n_reset)
        net_valid_i |-> !$isunknown({net_id_i, net_op_i, net_addr_i, net_data_i}));

endmodule

// File: rtl/net_pkg.sv
package net_pkg;

    // Core ID width on the network
    localparam int kNetIdBits = 10;

    typedef logic [kNetIdBits-1:0] net_id_t;

    // Packet commands
    typedef enum logic [1:0] {
        NET_INSTR = 2'd0,
        NET_REG   = 2'd1,
        NET_PC    = 2'd2
    } net_op_e;

    // Run state of the core
    // IDLE waits for a PC write, ERR only leaves on reset
    typedef enum logic [1:0] {
        IDLE = 2'd0,
        RUN  = 2'd1,
        ERR  = 2'd2
    } core_state_e;

endpackage

// File: rtl/isa_pkg.sv
package isa_pkg;

    // Datapath and register file widths
    localparam int kDataBits = 32;
    localparam int kRegAddrBits = 5;
    localparam int kNumRegs = 32;

    // Instruction memory geometry
    localparam int kImemAddrBits = 10;
    localparam int kImemWords = 1024;
    localparam int kOpcodeBits = 6;

    typedef logic [kDataBits-1:0] data_t;
    typedef logic [kRegAddrBits-1:0] reg_addr_t;
    typedef logic [kImemAddrBits-1:0] imem_addr_t;

    // NOP must stay all zero, reset and flush rely on it
    typedef enum logic [kOpcodeBits-1:0] {
        NOP   = 6'd0,
        ADDU  = 6'd1,
        SUBU  = 6'd2,
        AND   = 6'd3,
        OR    = 6'd4,
        MOV   = 6'd5,
        BEQZ  = 6'd6,
        BNEQZ = 6'd7,
        JALR  = 6'd8,
        WAIT  = 6'd9
    } opcode_e;

    // 16-bit instruction, rs_imm doubles as signed branch offset
    typedef struct packed {
        opcode_e   opcode;
        reg_addr_t rd;
        reg_addr_t rs_imm;
    } instr_t;

    // Opcodes that write rd on commit
    function automatic logic writes_rd(opcode_e op);
        return (op == ADDU) || (op == SUBU) || (op == AND) || (op == OR)
            || (op == MOV) || (op == JALR);
    endfunction

endpackage
